/* common/dispatch_if.sv */
// Dispatch bus: allocation strobes and one decoded instruction with operand ready bits
`timescale 1ns/1ps
interface dispatch_if;
    import issue_pkg::*;

    logic                  alloc_alu;
    logic                  alloc_lsu;
    logic                  alloc_mul;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] prs1;
    logic [REG_ADDR_W-1:0] prs2;
    logic [REG_ADDR_W-1:0] prd;
    logic                  prs1_ready;
    logic                  prs2_ready;

    modport dispatch (
        output alloc_alu, alloc_lsu, alloc_mul, pc, inst, prs1, prs2, prd, prs1_ready, prs2_ready
    );

    modport station (
        input alloc_alu, alloc_lsu, alloc_mul, pc, inst, prs1, prs2, prd, prs1_ready, prs2_ready
    );

endinterface

/* common/issue_pkg.sv */
// Issue package: field widths, opcodes, functional unit classes, instruction word views
package issue_pkg;

    parameter int REG_ADDR_W      = 5;
    parameter int XLEN            = 32;
    parameter int RS_SIZE_DEFAULT = 4;

    // Major opcodes handled by the dispatch decoder
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;

    // funct7 of the M extension
    parameter logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_LSU = 2'd1,
        CLASS_MUL = 2'd2
    } fu_class_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    // Same 32-bit word, register-register and immediate layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

/* hw/dispatch_stage.sv */
// Dispatch stage: class decode, pending-register scoreboard, holding register, station alloc
`timescale 1ns/1ps
module dispatch_stage (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             dispatch_valid_i,
    input  logic [issue_pkg::XLEN-1:0]       pc_i,
    input  logic [issue_pkg::XLEN-1:0]       inst_i,
    output logic                             dispatch_ready_o,
    input  logic                             alu_free_i,
    input  logic                             lsu_free_i,
    input  logic                             mul_free_i,
    input  logic                             cdb_en_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] cdb_tag_i,
    dispatch_if.dispatch                     disp
);
    import issue_pkg::*;

    inst_u                 dec;
    fu_class_e             dec_class;
    logic                  is_op;
    logic                  is_op_imm;
    logic                  is_load;
    logic                  is_store;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic                  dec_rdy1;
    logic                  dec_rdy2;
    logic [31:0]           pending;
    logic                  accept;
    logic                  alloc_any;

    // Holding register between acceptance and station write
    logic                  hold_valid;
    fu_class_e             hold_class;
    logic [XLEN-1:0]       hold_pc;
    logic [XLEN-1:0]       hold_inst;
    logic [REG_ADDR_W-1:0] hold_prs1;
    logic [REG_ADDR_W-1:0] hold_prs2;
    logic [REG_ADDR_W-1:0] hold_prd;
    logic                  hold_rdy1;
    logic                  hold_rdy2;

    // x0 is always ready; the held instruction's rd counts as pending
    function automatic logic src_ready(input logic [REG_ADDR_W-1:0] src);
        logic cdb_hit;
        logic hold_hit;
        cdb_hit  = cdb_en_i && (cdb_tag_i == src);
        hold_hit = hold_valid && (hold_prd == src);
        return (src == '0) || (!hold_hit && (!pending[src] || cdb_hit));
    endfunction

    assign dec       = inst_i;
    assign is_op     = (dec.r.opcode == OPC_OP);
    assign is_op_imm = (dec.i.opcode == OPC_OP_IMM);
    assign is_load   = (dec.i.opcode == OPC_LOAD);
    assign is_store  = (dec.r.opcode == OPC_STORE);

    // Unused sources map to x0, stores and branches write nothing
    assign dec_rs1 = (is_op || is_op_imm || is_load || is_store) ? dec.i.rs1 : '0;
    assign dec_rs2 = (is_op || is_store) ? dec.r.rs2 : '0;
    assign dec_rd  = (is_op || is_op_imm || is_load) ? dec.i.rd : '0;

    always_comb begin
        if (is_load || is_store) begin
            dec_class = CLASS_LSU;
        end else if (is_op && (dec.r.funct7 == F7_MULDIV)) begin
            dec_class = CLASS_MUL;
        end else begin
            dec_class = CLASS_ALU;
        end
        dec_rdy1 = src_ready(dec_rs1);
        dec_rdy2 = src_ready(dec_rs2);
    end

    assign disp.alloc_alu = hold_valid && (hold_class == CLASS_ALU) && alu_free_i;
    assign disp.alloc_lsu = hold_valid && (hold_class == CLASS_LSU) && lsu_free_i;
    assign disp.alloc_mul = hold_valid && (hold_class == CLASS_MUL) && mul_free_i;
    assign alloc_any      = disp.alloc_alu || disp.alloc_lsu || disp.alloc_mul;

    assign dispatch_ready_o = !hold_valid || alloc_any;
    assign accept           = dispatch_valid_i && dispatch_ready_o;

    assign disp.pc         = hold_pc;
    assign disp.inst       = hold_inst;
    assign disp.prs1       = hold_prs1;
    assign disp.prs2       = hold_prs2;
    assign disp.prd        = hold_prd;
    // Broadcast in the allocation cycle reaches the entry directly
    assign disp.prs1_ready = hold_rdy1 || (cdb_en_i && (cdb_tag_i == hold_prs1));
    assign disp.prs2_ready = hold_rdy2 || (cdb_en_i && (cdb_tag_i == hold_prs2));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hold_valid <= 1'b0;
            pending    <= '0;
        end else begin
            if (accept) begin
                hold_valid <= 1'b1;
            end else if (alloc_any) begin
                hold_valid <= 1'b0;
            end
            if (cdb_en_i) begin
                pending[cdb_tag_i] <= 1'b0;
            end
            if (alloc_any && (hold_prd != '0)) begin
                pending[hold_prd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_class <= dec_class;
            hold_pc    <= pc_i;
            hold_inst  <= inst_i;
            hold_prs1  <= dec_rs1;
            hold_prs2  <= dec_rs2;
            hold_prd   <= dec_rd;
            hold_rdy1  <= dec_rdy1;
            hold_rdy2  <= dec_rdy2;
        end else begin
            hold_rdy1  <= disp.prs1_ready;
            hold_rdy2  <= disp.prs2_ready;
        end
    end

    a_one_alloc: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({disp.alloc_alu, disp.alloc_lsu, disp.alloc_mul}));

endmodule

/* hw/ooo_issue.sv */
// Issue top level: dispatch stage feeding the ALU, LSU and MUL reservation stations
`timescale 1ns/1ps
module ooo_issue #(
    parameter int RS_SIZE = issue_pkg::RS_SIZE_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             dispatch_valid_i,
    input  logic [issue_pkg::XLEN-1:0]       pc_i,
    input  logic [issue_pkg::XLEN-1:0]       inst_i,
    output logic                             dispatch_ready_o,
    input  logic                             lsu_ready_i,
    input  logic                             cdb_en_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] cdb_tag_i,
    output logic                             alu_issue_o,
    output logic [issue_pkg::XLEN-1:0]       alu_pc_o,
    output logic [issue_pkg::XLEN-1:0]       alu_inst_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] alu_prs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] alu_prs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] alu_prd_o,
    output logic                             lsu_issue_o,
    output logic [issue_pkg::XLEN-1:0]       lsu_pc_o,
    output logic [issue_pkg::XLEN-1:0]       lsu_inst_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] lsu_prs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] lsu_prs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] lsu_prd_o,
    output logic                             mul_issue_o,
    output logic [issue_pkg::XLEN-1:0]       mul_pc_o,
    output logic [issue_pkg::XLEN-1:0]       mul_inst_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] mul_prs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] mul_prs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] mul_prd_o
);

    logic alu_free;
    logic lsu_free;
    logic mul_free;

    dispatch_if disp_bus ();

    dispatch_stage dispatch_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dispatch_valid_i (dispatch_valid_i),
        .pc_i             (pc_i),
        .inst_i           (inst_i),
        .dispatch_ready_o (dispatch_ready_o),
        .alu_free_i       (alu_free),
        .lsu_free_i       (lsu_free),
        .mul_free_i       (mul_free),
        .cdb_en_i         (cdb_en_i),
        .cdb_tag_i        (cdb_tag_i),
        .disp             (disp_bus.dispatch)
    );

    // ALU and multiplier accept every cycle
    rs #(.RS_SIZE(RS_SIZE)) rs_alu (
        .clk_i(clk_i), .reset_i(reset_i), .alloc_i(disp_bus.alloc_alu),
        .disp(disp_bus.station), .fu_ready_i(1'b1),
        .cdb_en_i(cdb_en_i), .cdb_tag_i(cdb_tag_i), .free_o(alu_free),
        .issue_o(alu_issue_o), .pc_o(alu_pc_o), .inst_o(alu_inst_o),
        .prs1_o(alu_prs1_o), .prs2_o(alu_prs2_o), .prd_o(alu_prd_o)
    );

    rs #(.RS_SIZE(RS_SIZE)) rs_lsu (
        .clk_i(clk_i), .reset_i(reset_i), .alloc_i(disp_bus.alloc_lsu),
        .disp(disp_bus.station), .fu_ready_i(lsu_ready_i),
        .cdb_en_i(cdb_en_i), .cdb_tag_i(cdb_tag_i), .free_o(lsu_free),
        .issue_o(lsu_issue_o), .pc_o(lsu_pc_o), .inst_o(lsu_inst_o),
        .prs1_o(lsu_prs1_o), .prs2_o(lsu_prs2_o), .prd_o(lsu_prd_o)
    );

    rs #(.RS_SIZE(RS_SIZE)) rs_mul (
        .clk_i(clk_i), .reset_i(reset_i), .alloc_i(disp_bus.alloc_mul),
        .disp(disp_bus.station), .fu_ready_i(1'b1),
        .cdb_en_i(cdb_en_i), .cdb_tag_i(cdb_tag_i), .free_o(mul_free),
        .issue_o(mul_issue_o), .pc_o(mul_pc_o), .inst_o(mul_inst_o),
        .prs1_o(mul_prs1_o), .prs2_o(mul_prs2_o), .prd_o(mul_prd_o)
    );

endmodule

/* ooo_issue.f */
common/issue_pkg.sv
common/dispatch_if.sv
hw/dispatch_stage.sv
rs/rs_entry.sv
rs/rs_select.sv
rs/rs.sv
hw/ooo_issue.sv
sim/ooo_issue_checks.sv
sim/ooo_issue_tb.sv

/* rs/rs.sv */
// Reservation station: RS_SIZE slots, selector, allocation age counter, issue port mux
`timescale 1ns/1ps
module rs #(
    parameter int RS_SIZE = issue_pkg::RS_SIZE_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             alloc_i,
    dispatch_if.station                      disp,
    input  logic                             fu_ready_i,
    input  logic                             cdb_en_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] cdb_tag_i,
    output logic                             free_o,
    output logic                             issue_o,
    output logic [issue_pkg::XLEN-1:0]       pc_o,
    output logic [issue_pkg::XLEN-1:0]       inst_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prd_o
);
    import issue_pkg::*;

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    logic [RS_SIZE-1:0]    slot_free;
    logic [RS_SIZE-1:0]    slot_ready;
    logic [RS_SIZE-1:0]    slot_grant;
    logic [RS_SIZE-1:0]    issue_grant;
    logic [IDX_W-1:0]      issue_idx;
    logic [7:0]            age_cnt;
    logic [7:0]            slot_age  [RS_SIZE];
    logic [7:0]            slot_wait [RS_SIZE];
    logic [XLEN-1:0]       slot_pc   [RS_SIZE];
    logic [XLEN-1:0]       slot_inst [RS_SIZE];
    logic [REG_ADDR_W-1:0] slot_prs1 [RS_SIZE];
    logic [REG_ADDR_W-1:0] slot_prs2 [RS_SIZE];
    logic [REG_ADDR_W-1:0] slot_prd  [RS_SIZE];

    // Stamp source, advances once per allocation
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            age_cnt <= '0;
        end else if (alloc_i) begin
            age_cnt <= age_cnt + 8'd1;
        end
    end

    for (genvar k = 0; k < RS_SIZE; k++) begin : g_slot
        rs_entry slot_i (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .alloc_i   (alloc_i && slot_grant[k]),
            .issue_i   (issue_grant[k] && fu_ready_i),
            .age_i     (age_cnt),
            .disp      (disp),
            .cdb_en_i  (cdb_en_i),
            .cdb_tag_i (cdb_tag_i),
            .free_o    (slot_free[k]),
            .ready_o   (slot_ready[k]),
            .age_o     (slot_age[k]),
            .pc_o      (slot_pc[k]),
            .inst_o    (slot_inst[k]),
            .prs1_o    (slot_prs1[k]),
            .prs2_o    (slot_prs2[k]),
            .prd_o     (slot_prd[k])
        );
        // Wait time modulo 256
        assign slot_wait[k] = age_cnt - slot_age[k];
    end

    rs_select #(.RS_SIZE(RS_SIZE)) select_i (
        .free_i        (slot_free),
        .ready_i       (slot_ready),
        .age_i         (slot_wait),
        .slot_grant_o  (slot_grant),
        .issue_grant_o (issue_grant),
        .issue_idx_o   (issue_idx)
    );

    assign free_o  = |slot_free;
    assign issue_o = (|issue_grant) && fu_ready_i;
    assign pc_o    = slot_pc[issue_idx];
    assign inst_o  = slot_inst[issue_idx];
    assign prs1_o  = slot_prs1[issue_idx];
    assign prs2_o  = slot_prs2[issue_idx];
    assign prd_o   = slot_prd[issue_idx];

endmodule

/* rs/rs_entry.sv */
// Reservation station slot: instruction fields, operand ready bits, age stamp, CDB snoop
`timescale 1ns/1ps
module rs_entry (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             alloc_i,
    input  logic                             issue_i,
    input  logic [7:0]                       age_i,
    dispatch_if.station                      disp,
    input  logic                             cdb_en_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] cdb_tag_i,
    output logic                             free_o,
    output logic                             ready_o,
    output logic [7:0]                       age_o,
    output logic [issue_pkg::XLEN-1:0]       pc_o,
    output logic [issue_pkg::XLEN-1:0]       inst_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prs2_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] prd_o
);

    logic busy;
    logic rdy1;
    logic rdy2;

    assign free_o  = !busy;
    assign ready_o = busy && rdy1 && rdy2;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
        end else if (alloc_i) begin
            busy <= 1'b1;
            rdy1 <= disp.prs1_ready;
            rdy2 <= disp.prs2_ready;
        end else begin
            if (issue_i) begin
                busy <= 1'b0;
            end
            // Wake-up on a matching tag
            if (cdb_en_i && (cdb_tag_i == prs1_o)) begin
                rdy1 <= 1'b1;
            end
            if (cdb_en_i && (cdb_tag_i == prs2_o)) begin
                rdy2 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            age_o  <= age_i;
            pc_o   <= disp.pc;
            inst_o <= disp.inst;
            prs1_o <= disp.prs1;
            prs2_o <= disp.prs2;
            prd_o  <= disp.prd;
        end
    end

    a_alloc_free: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_i |-> free_o);

    // Issue only from a ready slot, which is empty afterwards
    a_issue_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_i |-> ready_o ##1 free_o);

endmodule

/* rs/rs_select.sv */
// Slot selector: lowest free slot for allocation, oldest ready slot for issue
`timescale 1ns/1ps
module rs_select #(
    parameter int RS_SIZE = issue_pkg::RS_SIZE_DEFAULT
) (
    input  logic [RS_SIZE-1:0]                                free_i,
    input  logic [RS_SIZE-1:0]                                ready_i,
    input  logic [7:0]                                        age_i [RS_SIZE],
    output logic [RS_SIZE-1:0]                                slot_grant_o,
    output logic [RS_SIZE-1:0]                                issue_grant_o,
    output logic [((RS_SIZE > 1) ? $clog2(RS_SIZE) : 1)-1:0] issue_idx_o
);

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    // Scan from the top so the lowest free index wins
    always_comb begin
        slot_grant_o = '0;
        for (int k = RS_SIZE - 1; k >= 0; k--) begin
            if (free_i[k]) begin
                slot_grant_o    = '0;
                slot_grant_o[k] = 1'b1;
            end
        end
    end

    // age_i is the wait time, so larger means older
    always_comb begin
        logic [7:0] best_age;
        logic       found;
        best_age      = '0;
        found         = 1'b0;
        issue_idx_o   = '0;
        issue_grant_o = '0;
        for (int k = 0; k < RS_SIZE; k++) begin
            if (ready_i[k] && (!found || (age_i[k] > best_age))) begin
                found       = 1'b1;
                best_age    = age_i[k];
                issue_idx_o = IDX_W'(k);
            end
        end
        if (found) begin
            issue_grant_o[issue_idx_o] = 1'b1;
        end
    end

    always_comb begin
        a_grants: assert ($onehot0(slot_grant_o) && $onehot0(issue_grant_o)
                          && ((slot_grant_o & ~free_i) == '0)
                          && ((issue_grant_o & ~ready_i) == '0));
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the issue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ooo_issue_tb \
    -f ooo_issue.f -o sim_ooo_issue
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_ooo_issue 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* sim/ooo_issue_checks.sv */
// Port-level checker: LSU back-pressure, issue strobes and dispatch ready after reset
`timescale 1ns/1ps
module ooo_issue_checks (
    input  logic clk_i,
    input  logic reset_i,
    input  logic lsu_ready_i,
    input  logic dispatch_ready_o,
    input  logic alu_issue_o,
    input  logic lsu_issue_o,
    input  logic mul_issue_o,
    output logic fail_o
);

    initial fail_o = 1'b0;

    // The LSU stalls by holding lsu_ready_i low
    a_lsu_backpressure: assert property (@(posedge clk_i) disable iff (reset_i)
        !lsu_ready_i |-> !lsu_issue_o)
    else begin
        $display("CHECK FAILED t=%0t lsu_issue_o expected 0 got %b",
                 $time, $sampled(lsu_issue_o));
        fail_o = 1'b1;
    end

    // State right after a reset edge
    a_reset_strobes: assert property (@(posedge clk_i)
        reset_i |=> !alu_issue_o && !lsu_issue_o && !mul_issue_o)
    else begin
        $display("CHECK FAILED t=%0t issue strobes expected 000 got %b%b%b",
                 $time, $sampled(alu_issue_o), $sampled(lsu_issue_o),
                 $sampled(mul_issue_o));
        fail_o = 1'b1;
    end

    a_reset_ready: assert property (@(posedge clk_i)
        reset_i |=> dispatch_ready_o)
    else begin
        $display("CHECK FAILED t=%0t dispatch_ready_o expected 1 got %b",
                 $time, $sampled(dispatch_ready_o));
        fail_o = 1'b1;
    end

endmodule

/* sim/ooo_issue_tb.sv */
// Testbench: clock, reset, dispatch stimulus, unit and CDB model, reference scoreboard
`timescale 1ns/1ps
module ooo_issue_tb;
    import issue_pkg::*;

    localparam int RS_SIZE    = 4;
    localparam int MAX_CYCLES = 4000;
    localparam int NEVER      = 1 << 30;

    typedef struct {
        logic [31:0] pc;
        logic [31:0] inst;
        int          cls;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  rd;
        int          acc;
        int          rdy;
    } rec_t;

    logic        clk_i;
    logic        reset_i;
    logic        dispatch_valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic        dispatch_ready_o;
    logic        lsu_ready_i;
    logic        cdb_en_i;
    logic [4:0]  cdb_tag_i;
    logic        alu_issue_o;
    logic [31:0] alu_pc_o;
    logic [31:0] alu_inst_o;
    logic [4:0]  alu_prs1_o;
    logic [4:0]  alu_prs2_o;
    logic [4:0]  alu_prd_o;
    logic        lsu_issue_o;
    logic [31:0] lsu_pc_o;
    logic [31:0] lsu_inst_o;
    logic [4:0]  lsu_prs1_o;
    logic [4:0]  lsu_prs2_o;
    logic [4:0]  lsu_prd_o;
    logic        mul_issue_o;
    logic [31:0] mul_pc_o;
    logic [31:0] mul_inst_o;
    logic [4:0]  mul_prs1_o;
    logic [4:0]  mul_prs2_o;
    logic [4:0]  mul_prd_o;
    logic        check_fail;

    // Reference state with waiting instructions in acceptance order, pending set, CDB queue
    rec_t        waitq [$];
    int          bq_tag [$];
    int          bq_due [$];
    logic [31:0] pend;
    rec_t        cand;
    int          cyc;
    int          wd = 0;
    int          lsu_hold_until;
    logic [31:0] next_pc;
    logic [4:0]  last_rd;
    logic [4:0]  burst_src;
    bit          ready_s;
    bit          accepted;
    bit          burst_on;
    bit          saw_stall;
    bit          lsu_flaky;

    ooo_issue #(.RS_SIZE(RS_SIZE)) ooo_issue_i (.*);

    ooo_issue_checks checks_i (
        .clk_i(clk_i), .reset_i(reset_i), .lsu_ready_i(lsu_ready_i),
        .dispatch_ready_o(dispatch_ready_o), .alu_issue_o(alu_issue_o),
        .lsu_issue_o(lsu_issue_o), .mul_issue_o(mul_issue_o), .fail_o(check_fail)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge check_fail) stop_with_failure();

    always @(posedge clk_i) begin
        wd++;
        if (wd >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    function automatic bit src_free(input logic [4:0] s);
        return (s == 5'd0) || !pend[s];
    endfunction

    // Free destination that neither this instruction nor a waiting one reads
    function automatic logic [4:0] pick_rd(input logic [4:0] s1, input logic [4:0] s2);
        logic [4:0] r;
        bit         busy;
        for (int t = 0; t < 16; t++) begin
            r    = 5'($urandom_range(1, 15));
            busy = pend[r] || (r == s1) || (r == s2);
            foreach (waitq[k]) begin
                if (waitq[k].s1 == r || waitq[k].s2 == r) busy = 1'b1;
            end
            if (!busy) return r;
        end
        return 5'd0;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic make_cand(input int cls, input int src1);
        logic [4:0] s1;
        logic [4:0] s2;
        logic [4:0] rd;
        logic [2:0] f3;
        bit         alt;
        s1  = (src1 >= 0) ? 5'(src1) : 5'($urandom_range(0, 15));
        s2  = 5'($urandom_range(0, 15));
        rd  = pick_rd(s1, s2);
        f3  = 3'($urandom_range(0, 7));
        alt = ($urandom_range(0, 1) == 1);
        if (cls == 0 && alt) begin
            cand.inst = {12'($urandom), s1, f3, rd, OPC_OP_IMM};
            s2 = 5'd0;
        end else if (cls == 0) begin
            cand.inst = {7'b0000000, s2, s1, f3, rd, OPC_OP};
        end else if (cls == 1 && alt) begin
            cand.inst = {12'($urandom), s1, f3, rd, OPC_LOAD};
            s2 = 5'd0;
        end else if (cls == 1) begin
            // Store rd field holds immediate bits
            cand.inst = {7'($urandom), s2, s1, f3, 5'($urandom), OPC_STORE};
            rd = 5'd0;
        end else begin
            cand.inst = {F7_MULDIV, s2, s1, f3, rd, OPC_OP};
        end
        cand.cls = cls;
        cand.pc  = next_pc;
        cand.s1  = s1;
        cand.s2  = s2;
        cand.rd  = rd;
        next_pc  = next_pc + 32'd4;
    endtask

    // One driver clock that applies last broadcast and acceptance, then drives
    task automatic step();
        @(posedge clk_i);
        cyc++;
        if (cdb_en_i) begin
            pend[cdb_tag_i] = 1'b0;
            foreach (waitq[k]) begin
                if (waitq[k].rdy == NEVER && src_free(waitq[k].s1) && src_free(waitq[k].s2))
                    waitq[k].rdy = cyc;
            end
        end
        if (dispatch_valid_i && ready_s && !reset_i) begin
            cand.acc = cyc;
            cand.rdy = (src_free(cand.s1) && src_free(cand.s2)) ? cyc : NEVER;
            waitq.push_back(cand);
            if (cand.rd != 5'd0) pend[cand.rd] = 1'b1;
            accepted = 1'b1;
        end
        #10;
        cdb_en_i = 1'b0;
        if (bq_tag.size() > 0 && bq_due[0] <= cyc) begin
            cdb_en_i  = 1'b1;
            cdb_tag_i = 5'(bq_tag.pop_front());
            void'(bq_due.pop_front());
        end
        lsu_ready_i = (cyc >= lsu_hold_until) && (!lsu_flaky || $urandom_range(0, 2) != 0);
    endtask

    task automatic dispatch_one(input int cls, input int src1);
        make_cand(cls, src1);
        last_rd          = cand.rd;
        dispatch_valid_i = 1'b1;
        pc_i             = cand.pc;
        inst_i           = cand.inst;
        accepted         = 1'b0;
        while (!accepted) step();
        dispatch_valid_i = 1'b0;
        if ($urandom_range(0, 3) == 0) step();
    endtask

    task automatic wait_drain();
        while (waitq.size() > 0 || bq_tag.size() > 0) step();
        step();
    endtask

    task automatic check_issue(input int cls, input string port, input logic [31:0] pc,
                               input logic [31:0] inst, input logic [4:0] s1,
                               input logic [4:0] s2, input logic [4:0] rd);
        int idx;
        idx = -1;
        foreach (waitq[k]) begin
            if (idx < 0 && waitq[k].pc == pc) idx = k;
        end
        assert (idx >= 0) else begin
            $display("%s port issued pc %h, which is not waiting", port, pc);
            stop_with_failure();
        end
        check_field({port, "_issue_o class"}, waitq[idx].cls, cls);
        check_field({port, "_inst_o"}, waitq[idx].inst, inst);
        check_field({port, "_prs1_o"}, waitq[idx].s1, s1);
        check_field({port, "_prs2_o"}, waitq[idx].s2, s2);
        check_field({port, "_prd_o"}, waitq[idx].rd, rd);
        assert (src_free(s1) && src_free(s2)) else begin
            $display("%s port issued pc %h with a pending source", port, pc);
            stop_with_failure();
        end
        for (int k = 0; k < idx; k++) begin
            assert (!(waitq[k].cls == cls && waitq[k].acc <= cyc - 2
                      && waitq[k].rdy <= cyc - 2)) else begin
                $display("%s port issued pc %h before older ready pc %h", port, pc,
                         waitq[k].pc);
                stop_with_failure();
            end
        end
        if (rd != 5'd0) begin
            bq_tag.push_back(int'(rd));
            bq_due.push_back(cyc + int'($urandom_range(1, 4)));
        end
        waitq.delete(idx);
    endtask

    // Outputs are stable by the falling edge
    always @(negedge clk_i) begin
        ready_s = dispatch_ready_o;
        if (burst_on && !dispatch_ready_o) saw_stall = 1'b1;
        if (!reset_i) begin
            if (alu_issue_o)
                check_issue(0, "alu", alu_pc_o, alu_inst_o, alu_prs1_o, alu_prs2_o, alu_prd_o);
            if (lsu_issue_o)
                check_issue(1, "lsu", lsu_pc_o, lsu_inst_o, lsu_prs1_o, lsu_prs2_o, lsu_prd_o);
            if (mul_issue_o)
                check_issue(2, "mul", mul_pc_o, mul_inst_o, mul_prs1_o, mul_prs2_o, mul_prd_o);
        end
    end

    initial begin
        void'($urandom(32'hdd01));
        reset_i          = 1'b1;
        dispatch_valid_i = 1'b0;
        pc_i             = '0;
        inst_i           = '0;
        lsu_ready_i      = 1'b1;
        cdb_en_i         = 1'b0;
        cdb_tag_i        = '0;
        pend             = '0;
        cyc              = 0;
        next_pc          = 32'h0000_1000;
        lsu_hold_until   = 0;
        lsu_flaky        = 1'b0;
        burst_on         = 1'b0;
        saw_stall        = 1'b0;
        ready_s          = 1'b0;
        accepted         = 1'b0;
        repeat (8) step();
        reset_i = 1'b0;

        // Random dependent streams
        repeat (120) dispatch_one(int'($urandom_range(0, 2)), -1);
        wait_drain();

        // Multiplies stuck behind a load that the LSU holds back
        lsu_hold_until = cyc + 40;
        do dispatch_one(1, -1); while (last_rd == 5'd0);
        burst_src = last_rd;
        burst_on  = 1'b1;
        repeat (RS_SIZE + 4) dispatch_one(2, int'(burst_src));
        burst_on = 1'b0;
        wait_drain();

        // Mostly memory traffic with a flaky LSU
        lsu_flaky = 1'b1;
        repeat (60) dispatch_one(($urandom_range(0, 3) == 0) ? 0 : 1, -1);
        lsu_flaky = 1'b0;

        wait_drain();
        if (saw_stall) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("dispatch_ready_o never fell during the multiply burst");
            stop_with_failure();
        end
    end

endmodule
